//--- design/i3c_bit_shifter.sv
// Per-byte datapath: bit counter, receive shift register, transmit bit select and host ACK
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_bit_shifter
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  i3c_bus_t               bus_i,
  input  logic                   byte_clr_i,
  input  logic [`I3C_BYTE_W-1:0] tx_data_i,
  output logic [3:0]             bit_idx_o,
  output logic                   bit_ack_o,
  output logic [`I3C_BYTE_W-1:0] rx_byte_o,
  output logic                   tx_bit_o,
  output logic                   host_ack_o
);

  logic [3:0]             bit_idx_q;
  logic [`I3C_BYTE_W-1:0] rx_byte_q;
  logic                   host_ack_q;

  // Ninth slot of a byte is the ACK bit
  assign bit_ack_o = (bit_idx_q == 4'(`I3C_BYTE_W));

  // Index moves on each SCL fall and wraps after the ACK slot
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bit_idx_q <= '0;
    end else if (bus_i.start || byte_clr_i) begin
      bit_idx_q <= '0;
    end else if (bus_i.scl_fall) begin
      bit_idx_q <= bit_ack_o ? 4'd0 : bit_idx_q + 4'd1;
    end
  end

  // MSB arrives first, the ACK slot is not shifted in
  always_ff @(posedge clk_i) begin
    if (byte_clr_i) begin
      rx_byte_q <= '0;
    end else if (bus_i.scl_rise && !bit_ack_o) begin
      rx_byte_q <= {rx_byte_q[`I3C_BYTE_W-2:0], bus_i.sda};
    end
  end

  // Host pulls SDA low to ACK our byte
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      host_ack_q <= 1'b0;
    end else if (bus_i.scl_rise && bit_ack_o) begin
      host_ack_q <= ~bus_i.sda;
    end
  end

  // Index 0 selects bit 7
  assign tx_bit_o   = tx_data_i[~bit_idx_q[2:0]];
  assign bit_idx_o  = bit_idx_q;
  assign rx_byte_o  = rx_byte_q;
  assign host_ack_o = host_ack_q;

endmodule

`default_nettype wire

//--- design/i3c_bus_monitor.sv
// Bus front end: synchronizes SCL and SDA, derives their edges and flags START and STOP
`timescale 1ns/1ps
`default_nettype none

module i3c_bus_monitor
  import i3c_target_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     scl_i,
  input  logic     sda_i,
  output i3c_bus_t bus_o
);

  logic [1:0] scl_sync_q;
  logic [1:0] sda_sync_q;
  logic       scl_s;
  logic       sda_s;
  i3c_bus_t   bus_q;

  // Two-flop synchronizers, idle bus reads high
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      scl_sync_q <= 2'b11;
      sda_sync_q <= 2'b11;
    end else begin
      scl_sync_q <= {scl_sync_q[0], scl_i};
      sda_sync_q <= {sda_sync_q[0], sda_i};
    end
  end

  assign scl_s = scl_sync_q[1];
  assign sda_s = sda_sync_q[1];

  // Edge register, bus_q holds the previous levels for comparison
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bus_q <= '{scl: 1'b1, sda: 1'b1, default: 1'b0};
    end else begin
      bus_q.scl      <= scl_s;
      bus_q.sda      <= sda_s;
      bus_q.scl_rise <= scl_s & ~bus_q.scl;
      bus_q.scl_fall <= ~scl_s & bus_q.scl;
      // SDA moving while SCL stays high marks a START or STOP
      bus_q.start    <= bus_q.sda & ~sda_s & bus_q.scl & scl_s;
      bus_q.stop     <= ~bus_q.sda & sda_s & bus_q.scl & scl_s;
    end
  end

  assign bus_o = bus_q;

endmodule

`default_nettype wire

//--- design/i3c_target_config.sv
// Settings register of the target, updated from software only while no transfer is running
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_target_config
  import i3c_target_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  input  logic     we_i,
  input  i3c_cfg_t cfg_i,
  input  logic     idle_i,
  output i3c_cfg_t cfg_o
);

  i3c_cfg_t cfg_q;

  // Out of reset the target is disabled with default address and hold
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      cfg_q.enable   <= 1'b0;
      cfg_q.own_addr <= `I3C_DEF_ADDR;
      cfg_q.thd      <= `I3C_CNT_W'(`I3C_DEF_THD);
    end else if (we_i && idle_i) begin
      // Writes during a transfer are dropped
      // so address and timing stay fixed until STOP
      cfg_q <= cfg_i;
    end
  end

  assign cfg_o = cfg_q;

endmodule

`default_nettype wire

//--- design/i3c_target_fsm.sv
// Transfer FSM: address match, ACK timing, byte receive and transmit, SDA drive and events
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_target_fsm
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  i3c_bus_t               bus_i,
  input  i3c_cfg_t               cfg_i,
  input  logic [3:0]             bit_idx_i,
  input  logic                   bit_ack_i,
  input  logic [`I3C_BYTE_W-1:0] rx_byte_i,
  input  logic                   tx_bit_i,
  input  logic                   host_ack_i,
  input  logic                   tx_valid_i,
  output logic                   byte_clr_o,
  output logic                   sda_o,
  output logic                   idle_o,
  output logic                   transmitting_o,
  output logic                   tx_ready_o,
  output logic                   rx_valid_o,
  output logic [`I3C_BYTE_W-1:0] rx_data_o,
  output i3c_evt_t               evt_o
);

  i3c_state_e            state_q, state_d;
  logic [`I3C_CNT_W-1:0] tcount_q;
  logic                  load_tcount;
  logic                  hold_done;
  logic                  last_bit_fall;
  logic                  addr_match;
  logic                  sda_q, sda_d;
  // Transfer addressed to us, its direction, and the early-SCL NACK latch
  logic                  xfer_q, xfer_d;
  logic                  rnw_q, rnw_d;
  logic                  nack_q, nack_d;

  // Count of 1 or 0 ends a hold, so thd of zero does not wrap
  assign hold_done     = (tcount_q[`I3C_CNT_W-1:1] == '0);
  assign last_bit_fall = bus_i.scl_fall && (bit_idx_i == 4'd7);
  assign addr_match    = (rx_byte_i[`I3C_BYTE_W-1:1] == cfg_i.own_addr);

  always_comb begin
    state_d     = state_q;
    load_tcount = 1'b0;
    sda_d       = 1'b1;
    xfer_d      = xfer_q;
    rnw_d       = rnw_q;
    nack_d      = nack_q;
    byte_clr_o  = 1'b0;
    tx_ready_o  = 1'b0;
    rx_valid_o  = 1'b0;
    evt_o       = '0;
    unique case (state_q)
      Idle: begin
        xfer_d = 1'b0;
        rnw_d  = 1'b0;
        nack_d = 1'b0;
      end
      // START ends once SCL goes low
      AcquireStart: begin
        xfer_d = 1'b0;
        if (!bus_i.scl) begin
          byte_clr_o = 1'b1;
          state_d    = AddrRead;
        end
      end
      AddrRead: begin
        if (last_bit_fall) begin
          if (addr_match) begin
            xfer_d      = 1'b1;
            rnw_d       = rx_byte_i[0];
            load_tcount = 1'b1;
            state_d     = AddrAckWait;
          end else begin
            state_d = WaitForStop;
          end
        end
      end
      // Host clocking before our hold elapsed, give up on this transfer
      AddrAckWait, AcquireAckWait: begin
        if (bus_i.scl) begin
          nack_d  = 1'b1;
          state_d = WaitForStop;
        end else if (hold_done) begin
          state_d = (state_q == AddrAckWait) ? AddrAckSetup : AcquireAckSetup;
        end
      end
      AddrAckSetup, AcquireAckSetup: begin
        sda_d = 1'b0;
        if (bus_i.scl) begin
          state_d = (state_q == AddrAckSetup) ? AddrAckPulse : AcquireAckPulse;
        end
      end
      // Keep ACK low across SCL high, then hold thd after the fall
      AddrAckPulse, AcquireAckPulse: begin
        sda_d = 1'b0;
        if (!bus_i.scl) begin
          load_tcount = 1'b1;
          state_d     = (state_q == AddrAckPulse) ? AddrAckHold : AcquireAckHold;
        end
      end
      AddrAckHold: begin
        sda_d = 1'b0;
        if (hold_done) begin
          evt_o.read_cmd = rnw_q;
          state_d        = rnw_q ? TransmitWait : AcquireByte;
        end
      end
      AcquireAckHold: begin
        sda_d = 1'b0;
        if (hold_done) begin
          rx_valid_o = 1'b1;
          state_d    = AcquireByte;
        end
      end
      AcquireByte: begin
        if (last_bit_fall) begin
          load_tcount = 1'b1;
          state_d     = AcquireAckWait;
        end
      end
      // SDA stays released until a byte is offered
      TransmitWait: begin
        if (tx_valid_i) begin
          state_d = TransmitSetup;
        end
      end
      TransmitSetup: begin
        sda_d = tx_bit_i;
        if (bus_i.scl) begin
          state_d = TransmitPulse;
        end
      end
      TransmitPulse: begin
        sda_d = sda_q;
        if (!bus_i.scl) begin
          load_tcount = 1'b1;
          state_d     = TransmitHold;
        end
      end
      // Index has already moved on, so the bit comes from sda_q
      TransmitHold: begin
        sda_d = sda_q;
        if (hold_done) begin
          state_d = bit_ack_i ? TransmitAck : TransmitSetup;
        end
      end
      TransmitAck: begin
        if (bus_i.scl) begin
          state_d = TransmitAckPulse;
        end
      end
      // Byte is popped on ACK and NACK alike
      TransmitAckPulse: begin
        if (!bus_i.scl) begin
          tx_ready_o = 1'b1;
          state_d    = host_ack_i ? TransmitWait : WaitForStop;
        end
      end
      // WaitForStop only leaves through the overrides below
      default: begin
        state_d = state_q;
      end
    endcase

    // Bus conditions and enable take priority over the per-state moves
    if (!cfg_i.enable) begin
      state_d = Idle;
    end else if (bus_i.start) begin
      state_d = AcquireStart;
    end else if (bus_i.stop) begin
      state_d = Idle;
    end

    evt_o.target_nack  = nack_d & ~nack_q;
    evt_o.cmd_complete = cfg_i.enable & bus_i.stop & xfer_q;
    // A read should end with host NACK, which lands in WaitForStop
    evt_o.unexp_stop   = cfg_i.enable & bus_i.stop & xfer_q & rnw_q &
                         (state_q != WaitForStop);
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q  <= Idle;
      sda_q    <= 1'b1;
      xfer_q   <= 1'b0;
      rnw_q    <= 1'b0;
      nack_q   <= 1'b0;
      tcount_q <= '0;
    end else begin
      state_q <= state_d;
      sda_q   <= sda_d;
      xfer_q  <= xfer_d;
      rnw_q   <= rnw_d;
      nack_q  <= nack_d;
      if (load_tcount) begin
        tcount_q <= cfg_i.thd;
      end else if (tcount_q != '0) begin
        tcount_q <= tcount_q - `I3C_CNT_W'(1);
      end
    end
  end

  assign sda_o          = sda_d;
  assign idle_o         = (state_q == Idle);
  assign rx_data_o      = rx_byte_i;
  assign transmitting_o = state_q inside {AddrAckSetup, AddrAckPulse, AddrAckHold,
                                          TransmitSetup, TransmitPulse, TransmitHold,
                                          AcquireAckSetup, AcquireAckPulse, AcquireAckHold};

endmodule

`default_nettype wire

//--- design/i3c_target_pkg.sv
// Types shared by the I3C target blocks: configuration, bus view, events and FSM states
`default_nettype none

`include "i3c_target_settings.svh"

package i3c_target_pkg;

  // Active target settings
  typedef struct packed {
    logic                  enable;
    logic [`I3C_ADDR_W-1:0] own_addr;
    logic [`I3C_CNT_W-1:0]  thd;
  } i3c_cfg_t;

  // Synchronized levels plus one-cycle edge and condition pulses
  typedef struct packed {
    logic scl;
    logic sda;
    logic scl_rise;
    logic scl_fall;
    logic start;
    logic stop;
  } i3c_bus_t;

  // Event pulses towards the system
  typedef struct packed {
    logic cmd_complete;
    logic target_nack;
    logic unexp_stop;
    logic read_cmd;
  } i3c_evt_t;

  typedef enum logic [4:0] {
    Idle, AcquireStart, AddrRead,
    AddrAckWait, AddrAckSetup, AddrAckPulse, AddrAckHold,
    TransmitWait, TransmitSetup, TransmitPulse, TransmitHold, TransmitAck, TransmitAckPulse,
    AcquireByte, AcquireAckWait, AcquireAckSetup, AcquireAckPulse, AcquireAckHold,
    WaitForStop
  } i3c_state_e;

endpackage

`default_nettype wire

//--- design/i3c_target_settings.svh
// Widths and reset defaults of the I3C target, included by the package and the RTL modules
`ifndef I3C_TARGET_SETTINGS_SVH
`define I3C_TARGET_SETTINGS_SVH

// Static address width
`define I3C_ADDR_W 7

// Bus byte width
`define I3C_BYTE_W 8

// Hold-time counter width
`define I3C_CNT_W 16

// Settings applied out of reset
`define I3C_DEF_ADDR 7'h2a
`define I3C_DEF_THD 3

`endif

//--- design/i3c_target_top.sv
// Top level of the I3C target: bus monitor, settings register, bit shifter and transfer FSM
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module i3c_target_top
  import i3c_target_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   scl_i,
  input  logic                   sda_i,
  output logic                   sda_o,
  output logic                   target_idle_o,
  output logic                   target_transmitting_o,
  input  logic                   cfg_we_i,
  input  i3c_cfg_t               cfg_i,
  input  logic                   tx_valid_i,
  input  logic [`I3C_BYTE_W-1:0] tx_data_i,
  output logic                   tx_ready_o,
  output logic                   rx_valid_o,
  output logic [`I3C_BYTE_W-1:0] rx_data_o,
  output i3c_evt_t               evt_o
);

  i3c_bus_t               bus;
  i3c_cfg_t               cfg;
  logic [3:0]             bit_idx;
  logic                   bit_ack;
  logic [`I3C_BYTE_W-1:0] rx_byte;
  logic                   tx_bit;
  logic                   host_ack;
  logic                   byte_clr;
  logic                   idle;

  i3c_bus_monitor u_bus_monitor (
    .clk_i, .rst_ni, .scl_i, .sda_i, .bus_o(bus)
  );

  // Idle from the FSM gates configuration updates
  i3c_target_config u_config (
    .clk_i, .rst_ni, .we_i(cfg_we_i), .cfg_i, .idle_i(idle), .cfg_o(cfg)
  );

  i3c_bit_shifter u_bit_shifter (
    .clk_i, .rst_ni, .bus_i(bus), .byte_clr_i(byte_clr), .tx_data_i,
    .bit_idx_o(bit_idx), .bit_ack_o(bit_ack), .rx_byte_o(rx_byte),
    .tx_bit_o(tx_bit), .host_ack_o(host_ack)
  );

  i3c_target_fsm u_fsm (
    .clk_i, .rst_ni, .bus_i(bus), .cfg_i(cfg), .bit_idx_i(bit_idx), .bit_ack_i(bit_ack),
    .rx_byte_i(rx_byte), .tx_bit_i(tx_bit), .host_ack_i(host_ack), .tx_valid_i,
    .byte_clr_o(byte_clr), .sda_o, .idle_o(idle), .transmitting_o(target_transmitting_o),
    .tx_ready_o, .rx_valid_o, .rx_data_o, .evt_o
  );

  assign target_idle_o = idle;

endmodule

`default_nettype wire

//--- dv/i3c_target_properties.sv
// Concurrent checks on the target top level that the testbench attaches to the DUT by bind
`timescale 1ns/1ps
`default_nettype none

module i3c_target_properties
  import i3c_target_pkg::*;
(
  input logic       clk_i,
  input logic       rst_ni,
  input i3c_state_e state_i,
  input logic       scl_i,
  input logic       sda_i,
  input logic       idle_i,
  input logic       rx_valid_i,
  input logic       tx_ready_i,
  input i3c_evt_t   evt_i
);

  // Assertion failures seen so far
  int unsigned err_cnt = 0;

  // ACK hold ends while the host still keeps SCL low
  ack_before_scl: assert property (@(posedge clk_i) disable iff (!rst_ni)
    state_i inside {AddrAckWait, AcquireAckWait} |-> !scl_i)
    else begin
      $error("SCL rose before the target ACK was set up");
      err_cnt++;
    end

  // Receive strobe lands in the SCL low phase after the data ACK
  rx_in_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    rx_valid_i |-> !scl_i)
    else begin
      $error("rx_valid_o while SCL is high");
      err_cnt++;
    end

  // Byte pop follows the SCL fall after the host ACK slot
  pop_in_low: assert property (@(posedge clk_i) disable iff (!rst_ni)
    tx_ready_i |-> !scl_i)
    else begin
      $error("tx_ready_o while SCL is high");
      err_cnt++;
    end

  // Target SDA holds while SCL is high and so never fakes a START or STOP
  sda_stable_high: assert property (@(posedge clk_i) disable iff (!rst_ni)
    scl_i && $past(scl_i) |-> $stable(sda_i))
    else begin
      $error("sda_o moved while SCL was high");
      err_cnt++;
    end

  // FSM is back in idle one clock after a completed command
  idle_after_stop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    evt_i.cmd_complete |=> idle_i)
    else begin
      $error("target did not return to idle after cmd_complete");
      err_cnt++;
    end

endmodule

`default_nettype wire

//--- dv/tb_i3c_target.sv
// Testbench of the I3C target with a bit-banged bus host, stimulus sequences and result checks
`timescale 1ns/1ps
`default_nettype none

`include "i3c_target_settings.svh"

module tb_i3c_target
  import i3c_target_pkg::*;
();

  localparam int HALF = 20;
  localparam int TIMEOUT = 2000;

  logic clk, rst_n, scl, sda_host, cfg_we, tx_valid;
  logic sda_o, idle, xmit, tx_ready, rx_valid, sda_line;
  logic [`I3C_BYTE_W-1:0] tx_data, rx_data, b;
  i3c_cfg_t cfg;
  i3c_evt_t evt;
  int seed = 32'h612f;
  // Expected receive bytes and event counters
  logic [`I3C_BYTE_W-1:0] exp_rx[$];
  int rx_cnt, ready_cnt, done_cnt, unexp_cnt, rd_cnt, low_cnt;

  // Open-drain line
  assign sda_line = sda_host & sda_o;

  i3c_target_top uut (
    .clk_i(clk), .rst_ni(rst_n), .scl_i(scl), .sda_i(sda_line), .sda_o(sda_o),
    .target_idle_o(idle), .target_transmitting_o(xmit), .cfg_we_i(cfg_we), .cfg_i(cfg),
    .tx_valid_i(tx_valid), .tx_data_i(tx_data), .tx_ready_o(tx_ready),
    .rx_valid_o(rx_valid), .rx_data_o(rx_data), .evt_o(evt)
  );

  bind i3c_target_top i3c_target_properties props (
    .clk_i(clk_i), .rst_ni(rst_ni), .state_i(u_fsm.state_q), .scl_i(scl_i), .sda_i(sda_o),
    .idle_i(target_idle_o), .rx_valid_i(rx_valid_o), .tx_ready_i(tx_ready_o), .evt_i(evt_o)
  );

  task automatic fail(input string msg);
    $display("%s", msg);
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped");
  endtask

  task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got == exp)
      else fail($sformatf("** Error: %s got 0x%0h expected 0x%0h", name, got, exp));
  endtask

  task automatic half_wait();
    repeat (HALF) @(negedge clk);
  endtask

  task automatic send_bit(input logic v);
    sda_host = v;
    half_wait();
    scl = 1'b1;
    half_wait();
    scl = 1'b0;
  endtask

  task automatic wait_idle();
    int n;
    n = 0;
    while (!idle && n < TIMEOUT) begin
      @(negedge clk);
      n++;
    end
    if (!idle) fail("Timeout: target did not return to idle");
  endtask

  task automatic start_cond();
    sda_host = 1'b1;
    scl = 1'b1;
    half_wait();
    sda_host = 1'b0;
    half_wait();
    scl = 1'b0;
  endtask

  task automatic stop_cond();
    sda_host = 1'b0;
    half_wait();
    scl = 1'b1;
    half_wait();
    sda_host = 1'b1;
    half_wait();
    wait_idle();
  endtask

  // Sends eight data bits and checks the ACK slot at its SCL rise
  task automatic write_byte(input logic [7:0] v, input logic exp_ack);
    for (int i = 7; i >= 0; i--) send_bit(v[i]);
    sda_host = 1'b1;
    half_wait();
    scl = 1'b1;
    check_eq("sda_o (ack)", 32'(sda_o), 32'(!exp_ack));
    check_eq("target_transmitting_o", 32'(xmit), 32'(exp_ack));
    half_wait();
    scl = 1'b0;
  endtask

  // Reads nbits MSB first and answers a full byte with the host ACK bit
  task automatic read_byte(input int nbits, input logic ack);
    for (int i = 7; i > 7 - nbits; i--) begin
      sda_host = 1'b1;
      half_wait();
      scl = 1'b1;
      check_eq("sda_o (data)", 32'(sda_o), 32'(tx_data[i]));
      check_eq("target_transmitting_o", 32'(xmit), 32'd1);
      half_wait();
      scl = 1'b0;
    end
    if (nbits == 8) send_bit(!ack);
  endtask

  task automatic write_cfg(input logic [`I3C_ADDR_W-1:0] addr);
    cfg = '{enable: 1'b1, own_addr: addr, thd: `I3C_CNT_W'(`I3C_DEF_THD)};
    cfg_we = 1'b1;
    @(negedge clk);
    cfg_we = 1'b0;
  endtask

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Strobe and event bookkeeping and the bound checker's failures
  always @(negedge clk) begin
    if (rst_n) begin
      if (rx_valid) begin
        if (exp_rx.size() == 0) fail("Unexpected receive strobe");
        check_eq("rx_data_o", 32'(rx_data), 32'(exp_rx.pop_front()));
        rx_cnt++;
      end
      if (tx_ready) ready_cnt++;
      if (evt.cmd_complete) done_cnt++;
      if (evt.unexp_stop) unexp_cnt++;
      if (evt.read_cmd) rd_cnt++;
      if (!sda_o) low_cnt++;
      if (uut.props.err_cnt != 0) fail("A bound assertion on the DUT failed");
    end
  end

  initial begin
    #1ms;
    fail("Timeout: simulation ran too long");
  end

  initial begin
    rst_n = 1'b0;
    scl = 1'b1;
    sda_host = 1'b1;
    cfg_we = 1'b0;
    cfg = '0;
    tx_valid = 1'b0;
    tx_data = '0;
    rx_cnt = 0;
    ready_cnt = 0;
    done_cnt = 0;
    unexp_cnt = 0;
    rd_cnt = 0;
    low_cnt = 0;
    repeat (8) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    // Reset values
    check_eq("sda_o", 32'(sda_o), 32'd1);
    check_eq("target_idle_o", 32'(idle), 32'd1);
    check_eq("target_transmitting_o", 32'(xmit), 32'd0);
    check_eq("rx_valid_o", 32'(rx_valid), 32'd0);
    check_eq("tx_ready_o", 32'(tx_ready), 32'd0);
    check_eq("evt_o", 32'(evt), 32'd0);
    write_cfg(`I3C_DEF_ADDR);
    // Write three bytes to our address
    start_cond();
    write_byte({`I3C_DEF_ADDR, 1'b0}, 1'b1);
    repeat (3) begin
      b = 8'($random(seed));
      exp_rx.push_back(b);
      write_byte(b, 1'b1);
    end
    stop_cond();
    check_eq("rx strobes", 32'(rx_cnt), 32'd3);
    check_eq("cmd_complete count", 32'(done_cnt), 32'd1);
    // Foreign address must never see the line pulled low
    low_cnt = 0;
    start_cond();
    write_byte({7'h33, 1'b0}, 1'b0);
    write_byte(8'h5a, 1'b0);
    stop_cond();
    check_eq("sda_o low cycles", 32'(low_cnt), 32'd0);
    check_eq("rx strobes", 32'(rx_cnt), 32'd3);
    check_eq("cmd_complete count", 32'(done_cnt), 32'd1);
    // Read two bytes and NACK the second one
    tx_data = 8'($random(seed));
    tx_valid = 1'b1;
    start_cond();
    write_byte({`I3C_DEF_ADDR, 1'b1}, 1'b1);
    read_byte(8, 1'b1);
    read_byte(8, 1'b0);
    // Line stays released after the NACK
    low_cnt = 0;
    stop_cond();
    check_eq("sda_o low cycles", 32'(low_cnt), 32'd0);
    check_eq("read_cmd count", 32'(rd_cnt), 32'd1);
    check_eq("tx_ready_o count", 32'(ready_cnt), 32'd2);
    check_eq("cmd_complete count", 32'(done_cnt), 32'd2);
    check_eq("unexp_stop count", 32'(unexp_cnt), 32'd0);
    // STOP inside a read byte with bit 3 high so the target releases SDA for it
    tx_data = 8'($random(seed)) | 8'h08;
    start_cond();
    write_byte({`I3C_DEF_ADDR, 1'b1}, 1'b1);
    read_byte(4, 1'b0);
    stop_cond();
    check_eq("unexp_stop count", 32'(unexp_cnt), 32'd1);
    check_eq("cmd_complete count", 32'(done_cnt), 32'd3);
    tx_valid = 1'b0;
    // Address change while busy is dropped
    start_cond();
    write_byte({`I3C_DEF_ADDR, 1'b0}, 1'b1);
    write_cfg(7'h15);
    b = 8'($random(seed));
    exp_rx.push_back(b);
    write_byte(b, 1'b1);
    stop_cond();
    start_cond();
    write_byte({7'h15, 1'b0}, 1'b0);
    stop_cond();
    // Same change while idle takes effect
    write_cfg(7'h15);
    start_cond();
    write_byte({7'h15, 1'b0}, 1'b1);
    b = 8'($random(seed));
    exp_rx.push_back(b);
    write_byte(b, 1'b1);
    stop_cond();
    check_eq("rx strobes", 32'(rx_cnt), 32'd5);
    check_eq("cmd_complete count", 32'(done_cnt), 32'd5);
    repeat (4) @(negedge clk);
    $display("*** PASSED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- i3c_target_top.f
+incdir+design
design/i3c_target_pkg.sv
design/i3c_bus_monitor.sv
design/i3c_target_config.sv
design/i3c_bit_shifter.sv
design/i3c_target_fsm.sv
design/i3c_target_top.sv
dv/i3c_target_properties.sv
dv/tb_i3c_target.sv

//--- run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass message
cd "$(dirname "$0")" &&
  verilator --binary --timing --assert -f i3c_target_top.f \
    --top-module tb_i3c_target -o sim_tb &&
  ./obj_dir/sim_tb 2>&1 | tee /dev/stderr | grep -qF '*** PASSED ***' &&
  echo "Simulation passed" ||
  { echo "Simulation failed"; exit 1; }
